//--- Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
RUN_FLAGS ?= +verilator+error+limit+100
PASS_RE   ?= \*\*\* TEST PASSED \*\*\*

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	-./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_RE)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/lsu_clock_gen.sv
module lsu_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int half_period  = 4;   // 8 unit clock period
    localparam int reset_cycles = 5;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset held over the first rising edges, released on an edge
    initial begin
        rst = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- sim/lsu_properties.sv
module lsu_properties #(
    parameter int read_latency = lsu_pkg::DEF_READ_LATENCY
) (
    input logic        clk,
    input logic        rst,
    input logic        load_start,
    input logic        busy,
    input logic        load_done,
    input logic [31:0] ar_addr,
    input logic        ar_valid,
    input logic        r_valid,
    input logic        r_ready
);
    logic accept;                  // start taken by the read master
    logic in_flight;               // accepted load not yet done
    logic bad_reset   = 1'b0;
    logic bad_latency = 1'b0;
    logic bad_pulse   = 1'b0;
    logic bad_owner   = 1'b0;
    logic bad_busy    = 1'b0;
    logic bad_ar      = 1'b0;
    logic bad_r       = 1'b0;
    logic assertion_failed;        // sticky, watched from the testbench

    assign accept = load_start & ~busy;
    assign assertion_failed = bad_reset | bad_latency | bad_pulse | bad_owner |
                              bad_busy | bad_ar | bad_r;

    always_ff @(posedge clk) begin
        if (rst) in_flight <= 1'b0;
        else if (accept) in_flight <= 1'b1;
        else if (load_done) in_flight <= 1'b0;   // never same cycle as accept
    end

    // channels quiet once reset has been seen
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !ar_valid && !r_ready && !load_done && !r_valid)
        else begin $error("channel active right after reset"); bad_reset = 1'b1; end

    a_latency: assert property (@(posedge clk) disable iff (rst)
        accept |-> ##(1 + read_latency) load_done)
        else begin $error("load_done not at 1 + read_latency"); bad_latency = 1'b1; end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst)
        load_done |=> !load_done)
        else begin $error("load_done longer than one cycle"); bad_pulse = 1'b1; end

    // a done needs its own accepted start, so dropped starts make none
    a_done_owned: assert property (@(posedge clk) disable iff (rst)
        load_done |-> in_flight)
        else begin $error("load_done without accepted start"); bad_owner = 1'b1; end

    a_busy_held: assert property (@(posedge clk) disable iff (rst)
        in_flight |-> busy)
        else begin $error("busy low during a load"); bad_busy = 1'b1; end

    // address latched at the start, starts during busy must not move it
    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar_valid || r_ready |=> $stable(ar_addr))
        else begin $error("read address changed during a load"); bad_ar = 1'b1; end

    // ready held until the data handshake
    a_r_stable: assert property (@(posedge clk) disable iff (rst)
        r_ready && !r_valid |=> r_ready)
        else begin $error("r_ready dropped before r_valid"); bad_r = 1'b1; end

endmodule

//--- sim/tb_lsu.sv
module tb_lsu;
    import lsu_pkg::*;

    localparam int mem_addr_w  = DEF_ADDR_W;
    localparam int mem_latency = DEF_READ_LATENCY;
    localparam int mem_words   = 2 ** mem_addr_w;
    localparam int idle_limit  = mem_words + 64;    // covers the reset sweep
    localparam int done_limit  = mem_latency + 16;

    logic        clk;
    logic        rst;
    logic        load_start;
    logic [31:0] load_addr;
    load_op_e    load_op;
    logic [31:0] load_data;
    logic        load_done;
    logic        busy;
    logic        store_en;
    logic [31:0] store_addr;
    logic [31:0] store_data;
    logic [3:0]  store_mask;

    logic [31:0] model_mem [0:mem_words-1];   // reference copy of the data memory
    logic [31:0] lfsr;
    int          loads_checked;

    lsu_clock_gen clock_gen (.clk(clk), .rst(rst));

    lsu_top #(
        .addr_w       (mem_addr_w),
        .read_latency (mem_latency)
    ) DUT (
        .clk        (clk),
        .rst        (rst),
        .load_start (load_start),
        .load_addr  (load_addr),
        .load_op    (load_op),
        .load_data  (load_data),
        .load_done  (load_done),
        .busy       (busy),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_mask (store_mask)
    );

    // names resolve inside lsu_top
    bind lsu_top lsu_properties #(.read_latency(read_latency)) u_props (
        .clk(clk), .rst(rst), .load_start(load_start), .busy(busy),
        .load_done(load_done), .ar_addr(ar_addr), .ar_valid(ar_valid),
        .r_valid(r_valid), .r_ready(r_ready)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at first error");
    endtask

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};   // one step per bit
        end
    endtask

    // word shifted down by the byte offset, then sized and extended
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input logic [2:0] op);
        logic [31:0] s;
        logic [31:0] r;
        s = model_mem[addr[mem_addr_w+1:2]] >> (8 * addr[1:0]);
        case (op)
            3'd1:    r = 32'($signed(s[7:0]));
            3'd2:    r = 32'(s[7:0]);
            3'd3:    r = 32'($signed(s[15:0]));
            3'd4:    r = 32'(s[15:0]);
            3'd5:    r = s;
            default: r = '0;   // none and codes 6, 7
        endcase
        return r;
    endfunction

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > idle_limit) abort_run("timeout while waiting for busy to go low");
        end while (busy);
    endtask

    task automatic do_store(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] mask);
        logic [mem_addr_w-1:0] idx;
        idx = addr[mem_addr_w+1:2];   // same wrap as the memory
        @(posedge clk);
        store_en   <= 1'b1;
        store_addr <= addr;
        store_data <= data;
        store_mask <= mask;
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) model_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
        @(posedge clk);
        store_en <= 1'b0;
    endtask

    // poke keeps load_start up with junk while busy, which must be ignored
    task automatic do_load(input logic [31:0] addr, input logic [2:0] op, input bit poke);
        logic [31:0] want;
        logic [31:0] junk;
        int          cycles;
        bit          seen;
        wait_idle();
        want = expected_load(addr, op);
        load_start <= 1'b1;
        load_addr  <= addr;
        load_op    <= load_op_e'(op);
        take_bits(32, junk);
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            @(posedge clk);
            cycles++;
            if (load_done) begin
                assert (load_data === want)
                    else abort_run($sformatf("Error: time %0t: load %h op %0d gave %h, want %h",
                                             $time, addr, op, load_data, want));
                loads_checked++;
                seen = 1'b1;
                load_start <= 1'b0;
            end else begin
                if (cycles > done_limit) abort_run("timeout while waiting for load_done");
                load_start <= poke && cycles < 3;
                if (poke) begin
                    load_addr <= junk;
                    load_op   <= load_op_e'(junk[2:0]);
                end
            end
        end
    endtask

    task automatic load_all_types(input logic [31:0] addr);
        for (int op = 1; op <= 5; op++) begin
            for (int off = 0; off < 4; off++) begin
                do_load({addr[31:2], 2'(off)}, 3'(op), 1'b0);
            end
        end
    endtask

    // assertion failures in the bound checker end the run here
    always @(posedge clk) begin
        if (DUT.u_props.assertion_failed)
            abort_run("a protocol or timing assertion in lsu_properties failed");
    end

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] m;
        int          cycles;
        load_start    = 1'b0;
        load_addr     = '0;
        load_op       = LOAD_NONE;
        store_en      = 1'b0;
        store_addr    = '0;
        store_data    = '0;
        store_mask    = '0;
        lfsr          = 32'h47c6_c5b6;
        loads_checked = 0;
        for (int i = 0; i < mem_words; i++) model_mem[i] = '0;

        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
            if (cycles > 32) abort_run("timeout while waiting for reset release");
        end while (rst);

        // cleared memory reads zero
        for (int i = 0; i < 4; i++) begin
            take_bits(32, a);
            load_all_types(a);
        end

        // top bits set in every byte and halfword
        do_store(32'h0000_0040, 32'h80ff_7f81, 4'hf);
        load_all_types(32'h0000_0040);

        for (int i = 0; i < 20; i++) begin
            take_bits(32, a);
            take_bits(32, d);
            take_bits(4, m);
            do_store(a, d, m[3:0]);
            load_all_types(a);
        end

        // no-load and unused codes on a nonzero word
        for (int off = 0; off < 4; off++) begin
            do_load(32'h0000_0040 + off, 3'd0, 1'b0);
            do_load(32'h0000_0040 + off, 3'd6, 1'b0);
            do_load(32'h0000_0040 + off, 3'd7, 1'b0);
        end

        // starts during busy
        for (int i = 0; i < 4; i++) begin
            take_bits(32, a);
            take_bits(3, m);
            do_load(a, (m[2:0] % 3'd5) + 3'd1, 1'b1);
        end

        repeat (4) @(posedge clk);
        if (!DUT.u_props.assertion_failed && loads_checked > 0) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            abort_run("checks missing or assertion failure at end of run");
        end
    end

endmodule

//--- source/lsu_data_sram.sv
module lsu_data_sram #(
    parameter int addr_w       = lsu_pkg::DEF_ADDR_W,
    parameter int read_latency = lsu_pkg::DEF_READ_LATENCY
) (
    input  logic        clk,
    input  logic        rst,
    // store strobe, byte address
    input  logic        store_en,
    input  logic [31:0] store_addr,
    input  logic [31:0] store_data,
    input  logic [3:0]  store_mask,
    // read address channel, word address
    input  logic [31:0] ar_addr,
    input  logic        ar_valid,
    output logic        ar_ready,
    // read data channel
    output logic        r_valid,
    output logic [31:0] r_data,
    input  logic        r_ready
);
    import lsu_pkg::*;

    localparam int depth = 2 ** addr_w;
    localparam int cnt_w = $clog2(read_latency + 1);

    logic [DATA_W-1:0] mem [0:depth-1];

    logic              sweeping;     // clearing memory after reset
    logic [addr_w-1:0] sweep_idx;
    logic              pending;      // read accepted, not yet returned
    logic [cnt_w-1:0]  cnt;          // cycles left before r_valid
    logic [addr_w-1:0] rd_idx;       // latched read word
    logic [addr_w-1:0] fetch_idx;
    logic [addr_w-1:0] st_idx;
    logic              ar_hs;
    logic              r_hs;
    logic              fetch;        // load r_data this edge

    assign ar_hs = ar_valid & ar_ready;
    assign r_hs  = r_valid & r_ready;

    // no new address while a read is out or the sweep runs
    assign ar_ready = ~pending & ~sweeping;

    assign st_idx    = store_addr[addr_w+1:2];   // upper bits wrap
    assign fetch_idx = ar_hs ? ar_addr[addr_w-1:0] : rd_idx;

    // latency 1 fetches right at the handshake
    assign fetch = (ar_hs && read_latency == 1) ||
                   (pending && !r_valid && cnt == cnt_w'(1));

    // reset sweep over every word
    always_ff @(posedge clk) begin
        if (rst) begin
            sweeping  <= 1'b1;
            sweep_idx <= '0;
        end else if (sweeping) begin
            sweep_idx <= sweep_idx + 1'b1;
            if (&sweep_idx) sweeping <= 1'b0;   // last word cleared
        end
    end

    // write port, sweep wins over stores
    always_ff @(posedge clk) begin
        if (sweeping) begin
            mem[sweep_idx] <= '0;
        end else if (store_en) begin
            for (int i = 0; i < 4; i++) begin
                if (store_mask[i]) mem[st_idx][8*i +: 8] <= store_data[8*i +: 8];
            end
        end
    end

    // read control
    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
            r_valid <= 1'b0;
            cnt     <= '0;
        end else if (ar_hs) begin
            pending <= 1'b1;
            cnt     <= cnt_w'(read_latency - 1);
            if (read_latency == 1) r_valid <= 1'b1;
        end else if (pending && !r_valid) begin
            if (cnt == cnt_w'(1)) r_valid <= 1'b1;   // latency reached
            cnt <= cnt - 1'b1;
        end else if (r_hs) begin
            pending <= 1'b0;
            r_valid <= 1'b0;
        end
    end

    // read payload, held with r_valid until taken
    always_ff @(posedge clk) begin
        if (ar_hs) rd_idx <= ar_addr[addr_w-1:0];
        if (fetch) r_data <= mem[fetch_idx];
    end

endmodule

//--- source/lsu_load_align.sv
module lsu_load_align (
    input  logic [31:0]       word,     // raw memory word
    input  logic [1:0]        offset,   // byte offset of the load
    input  lsu_pkg::load_op_e op,
    output logic [31:0]       data
);
    import lsu_pkg::*;

    logic [DATA_W-1:0] shifted;

    // bring the addressed byte down to lane 0
    always_comb begin
        case (offset)
            2'd0: shifted = word;
            2'd1: shifted = word >> 8;
            2'd2: shifted = word >> 16;
            2'd3: shifted = word >> 24;
            default: shifted = word;
        endcase
    end

    // pick size and extension
    always_comb begin
        case (op)
            LOAD_LB:  data = {{24{shifted[7]}}, shifted[7:0]};
            LOAD_LBU: data = {24'h0, shifted[7:0]};
            LOAD_LH:  data = {{16{shifted[15]}}, shifted[15:0]};
            LOAD_LHU: data = {16'h0, shifted[15:0]};
            LOAD_LW:  data = shifted;
            // LOAD_NONE and the unused codes
            default:  data = '0;
        endcase
    end

endmodule

//--- source/lsu_pkg.sv
package lsu_pkg;

    // width of data words and of byte addresses
    localparam int DATA_W = 32;

    // memory depth in words is 2**DEF_ADDR_W
    localparam int DEF_ADDR_W = 8;       // 256 words by default

    // cycles from address handshake to first cycle with rvalid high
    // must be at least 1
    localparam int DEF_READ_LATENCY = 2;

    // load type, same code points as the decode stage uses
    // codes 6 and 7 are unused and read back as zero
    typedef enum logic [2:0] {
        LOAD_NONE = 3'd0,   // no load, result forced to zero
        LOAD_LB   = 3'd1,   // byte, sign extended
        LOAD_LBU  = 3'd2,   // byte, zero extended
        LOAD_LH   = 3'd3,   // halfword, sign extended
        LOAD_LHU  = 3'd4,   // halfword, zero extended
        LOAD_LW   = 3'd5    // full word
    } load_op_e;

endpackage

//--- source/lsu_read_master.sv
module lsu_read_master (
    input  logic              clk,
    input  logic              rst,
    // load request from decode
    input  logic              load_start,
    input  logic [31:0]       load_addr,
    input  lsu_pkg::load_op_e load_op,
    // read address channel
    output logic [31:0]       ar_addr,    // word address
    output logic              ar_valid,
    input  logic              ar_ready,
    // read data channel, data itself goes straight to the aligner
    input  logic              r_valid,
    output logic              r_ready,
    // latched request fields for the aligner
    output logic [1:0]        offset,
    output lsu_pkg::load_op_e op,
    // status
    output logic              load_done,
    output logic              busy
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,   // ar_valid up, waiting for ar_ready
        DATA = 2'd2    // r_ready up, waiting for r_valid
    } state_e;

    state_e             state;
    logic [DATA_W-1:0]  addr_q;   // byte address of current load
    load_op_e           op_q;
    logic               accept;

    // memory still sweeping shows up as ar_ready low while idle
    assign busy   = (state != IDLE) | ~ar_ready;
    assign accept = load_start & ~busy;   // starts while busy are dropped

    // one load in flight
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (accept) state <= ADDR;
                ADDR: if (ar_ready) state <= DATA;    // address handshake
                DATA: if (r_valid) state <= IDLE;     // data handshake
                default: state <= IDLE;
            endcase
        end
    end

    // request payload, held for the whole load
    always_ff @(posedge clk) begin
        if (accept) begin
            addr_q <= load_addr;
            op_q   <= load_op;
        end
    end

    assign ar_addr  = {2'b00, addr_q[DATA_W-1:2]};  // drop byte offset
    assign ar_valid = (state == ADDR);
    assign r_ready  = (state == DATA);
    assign offset   = addr_q[1:0];
    assign op       = op_q;

    // done is the data handshake itself
    assign load_done = r_valid & r_ready;

endmodule

//--- source/lsu_top.sv
module lsu_top #(
    parameter int addr_w       = lsu_pkg::DEF_ADDR_W,
    parameter int read_latency = lsu_pkg::DEF_READ_LATENCY
) (
    input  logic              clk,
    input  logic              rst,
    // load side
    input  logic              load_start,
    input  logic [31:0]       load_addr,
    input  lsu_pkg::load_op_e load_op,
    output logic [31:0]       load_data,
    output logic              load_done,
    output logic              busy,
    // store side, straight to memory
    input  logic              store_en,
    input  logic [31:0]       store_addr,
    input  logic [31:0]       store_data,
    input  logic [3:0]        store_mask
);
    import lsu_pkg::*;

    // read channels
    logic [DATA_W-1:0] ar_addr;
    logic              ar_valid;
    logic              ar_ready;
    logic              r_valid;
    logic [DATA_W-1:0] r_data;
    logic              r_ready;

    // latched request fields for alignment
    logic [1:0]        offset;
    load_op_e          op;

    lsu_read_master u_read_master (
        .clk        (clk),
        .rst        (rst),
        .load_start (load_start),
        .load_addr  (load_addr),
        .load_op    (load_op),
        .ar_addr    (ar_addr),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .offset     (offset),
        .op         (op),
        .load_done  (load_done),
        .busy       (busy)
    );

    // combinational, valid only in the load_done cycle
    lsu_load_align u_load_align (
        .word   (r_data),
        .offset (offset),
        .op     (op),
        .data   (load_data)
    );

    lsu_data_sram #(
        .addr_w       (addr_w),
        .read_latency (read_latency)
    ) u_data_sram (
        .clk        (clk),
        .rst        (rst),
        .store_en   (store_en),
        .store_addr (store_addr),
        .store_data (store_data),
        .store_mask (store_mask),
        .ar_addr    (ar_addr),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_data     (r_data),
        .r_ready    (r_ready)
    );

endmodule

//--- tb.f
source/lsu_pkg.sv
source/lsu_read_master.sv
source/lsu_load_align.sv
source/lsu_data_sram.sv
source/lsu_top.sv
sim/lsu_clock_gen.sv
sim/lsu_properties.sv
sim/tb_lsu.sv
